// File: hw/isaPkg.sv
package isaPkg;

    typedef logic [4:0]  regIdxT;
    typedef logic [31:0] wordT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB                                   // lui goes straight through
    } aluOpT;

    //////////////////////////////////////////////////////////////////////
    // RV32I encodings, subset only
    //////////////////////////////////////////////////////////////////////
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opStore  = 7'b0100011;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;
    localparam logic [2:0] f3Sw     = 3'b010;

    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Sub    = 7'b0100000;

    typedef struct packed {
        logic   valid;
        logic   regWrite;
        logic   memWrite;
        logic   branch;
        logic   branchNe;
        logic   jump;
        logic   aluSrc;                            // 1: second operand is imm
        logic   resultSrc;                         // 1: result is pcPlus4
        aluOpT  aluOp;
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
        wordT   rd1Val;
        wordT   rd2Val;
        wordT   imm;
        wordT   pc;
        wordT   pcPlus4;
    } decodeBundleT;

    typedef struct packed {
        logic   valid;
        logic   regWrite;
        logic   memWrite;
        regIdxT rd;
        wordT   result;                            // also the store address
        wordT   storeData;
    } execBundleT;

endpackage

// File: hw/busPkg.sv
package busPkg;

    // both Wishbone ports are word wide
    localparam int adrWidth = 32;
    localparam int datWidth = 32;
    localparam int selWidth = 4;

    localparam logic [adrWidth-1:0] resetPc = '0;  // first fetch address

endpackage

// File: hw/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = isaPkg::execBundleT
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            q <= '0;                               // all-zero bundle is a bubble
        end else if (!stall) begin
            q <= d;
        end
    end

    // a squashed slot never reaches the next stage, even under stall
    assert property (@(posedge clk) disable iff (!rstN) flush |=> !q.valid)
        else $error("stageReg: valid bundle survived a flush");

endmodule

// File: hw/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input  logic         clk,
    input  logic         rstN,
    input  logic         stall,
    input  logic         redirect,
    input  isaPkg::wordT redirectPc,
    input  isaPkg::wordT iDatI,
    input  logic         iAck,
    output logic         iCyc,
    output logic         iStb,
    output isaPkg::wordT iAdr,
    output logic         instrValid,
    output isaPkg::wordT instr,
    output isaPkg::wordT instrPc
);

    typedef enum logic [1:0] {
        fsIdle,
        fsBusy,
        fsHold
    } fetchStateT;

    fetchStateT   state;
    isaPkg::wordT pc;
    isaPkg::wordT instrReg;
    isaPkg::wordT pendPc;
    logic         dropPend;                        // redirect seen mid-transfer

    assign iCyc       = (state == fsBusy);
    assign iStb       = (state == fsBusy);
    assign iAdr       = pc;
    assign instrValid = (state == fsHold);
    assign instr      = instrReg;
    assign instrPc    = pc;                        // pc only moves on accept

    //////////////////////////////////////////////////////////////////////
    // fetch FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= fsIdle;
            pc       <= busPkg::resetPc;
            dropPend <= 1'b0;
        end else begin
            case (state)
                fsIdle: begin
                    state <= fsBusy;
                    if (redirect) begin
                        pc <= redirectPc;
                    end
                end
                fsBusy: begin
                    if (iAck) begin
                        dropPend <= 1'b0;
                        if (redirect || dropPend) begin
                            state <= fsIdle;       // data is stale, bus idles a cycle
                            pc    <= redirect ? redirectPc : pendPc;
                        end else begin
                            state <= fsHold;
                        end
                    end else if (redirect) begin
                        dropPend <= 1'b1;
                    end
                end
                fsHold: begin
                    if (redirect) begin
                        state <= fsBusy;
                        pc    <= redirectPc;
                    end else if (!stall) begin
                        state <= fsBusy;
                        pc    <= pc + 32'd4;
                    end
                end
                default: state <= fsIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fsBusy && iAck) begin
            instrReg <= iDatI;
        end
        if (state == fsBusy && redirect) begin
            pendPc <= redirectPc;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) iStb |-> iCyc)
        else $error("fetchStage: iStb without iCyc");
    assert property (@(posedge clk) disable iff (!rstN)
        iCyc && !iAck |=> iCyc && $stable(iAdr))
        else $error("fetchStage: instruction request dropped before iAck");

endmodule

// File: hw/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  isaPkg::wordT         instr,
    input  isaPkg::wordT         instrPc,
    input  logic                 wbWrite,
    input  isaPkg::regIdxT       wbRd,
    input  isaPkg::wordT         wbData,
    output isaPkg::decodeBundleT bundle
);

    isaPkg::wordT   regs [32];
    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    isaPkg::regIdxT rs1;
    isaPkg::regIdxT rs2;
    isaPkg::wordT   immI;
    isaPkg::wordT   immS;
    isaPkg::wordT   immB;
    isaPkg::wordT   immU;
    isaPkg::wordT   immJ;
    logic           known;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    //////////////////////////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rstN && wbWrite && wbRd != '0) begin  // no writes while in reset
            regs[wbRd] <= wbData;
        end
    end

    // write-first read, x0 is hardwired
    function automatic isaPkg::wordT readReg(input isaPkg::regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        if (wbWrite && wbRd == idx) begin
            return wbData;
        end
        return regs[idx];
    endfunction

    function automatic isaPkg::aluOpT aluFromF3(input logic [2:0] f3);
        case (f3)
            isaPkg::f3Xor: return isaPkg::aluXor;
            isaPkg::f3Or:  return isaPkg::aluOr;
            isaPkg::f3And: return isaPkg::aluAnd;
            isaPkg::f3Slt: return isaPkg::aluSlt;
            default:       return isaPkg::aluAdd;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // control decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        bundle         = '0;
        known          = 1'b0;
        bundle.rs1     = rs1;
        bundle.rs2     = rs2;
        bundle.rd      = instr[11:7];
        bundle.rd1Val  = readReg(rs1);
        bundle.rd2Val  = readReg(rs2);
        bundle.pc      = instrPc;
        bundle.pcPlus4 = instrPc + 32'd4;
        case (opcode)
            isaPkg::opReg: begin
                known           = (funct3 inside {isaPkg::f3AddSub, isaPkg::f3Xor,
                                   isaPkg::f3Or, isaPkg::f3And, isaPkg::f3Slt})
                               && (funct7 == isaPkg::f7Base
                               || (funct7 == isaPkg::f7Sub && funct3 == isaPkg::f3AddSub));
                bundle.regWrite = 1'b1;
                bundle.aluOp    = aluFromF3(funct3);
                if (funct7 == isaPkg::f7Sub) begin
                    bundle.aluOp = isaPkg::aluSub;
                end
            end
            isaPkg::opImm: begin
                known           = funct3 inside {isaPkg::f3AddSub, isaPkg::f3Xor,
                                  isaPkg::f3Or, isaPkg::f3And};
                bundle.regWrite = 1'b1;
                bundle.aluSrc   = 1'b1;
                bundle.aluOp    = aluFromF3(funct3);
                bundle.imm      = immI;
            end
            isaPkg::opLui: begin
                known           = 1'b1;
                bundle.regWrite = 1'b1;
                bundle.aluSrc   = 1'b1;
                bundle.aluOp    = isaPkg::aluPassB;
                bundle.imm      = immU;
            end
            isaPkg::opBranch: begin
                known           = funct3 inside {isaPkg::f3Beq, isaPkg::f3Bne};
                bundle.branch   = 1'b1;
                bundle.branchNe = (funct3 == isaPkg::f3Bne);
                bundle.aluOp    = isaPkg::aluSub;  // compare by subtraction
                bundle.imm      = immB;
            end
            isaPkg::opJal: begin
                known            = 1'b1;
                bundle.regWrite  = 1'b1;
                bundle.jump      = 1'b1;
                bundle.resultSrc = 1'b1;
                bundle.imm       = immJ;
            end
            isaPkg::opStore: begin
                known           = (funct3 == isaPkg::f3Sw);
                bundle.memWrite = 1'b1;
                bundle.aluSrc   = 1'b1;
                bundle.imm      = immS;
            end
            default: known = 1'b0;
        endcase
        if (!(known && instrValid)) begin
            bundle = '0;                           // unsupported becomes a bubble
        end else begin
            bundle.valid = 1'b1;
        end
    end

endmodule

// File: hw/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                 stall,
    input  isaPkg::decodeBundleT in,
    input  logic                 wbWrite,
    input  isaPkg::regIdxT       wbRd,
    input  isaPkg::wordT         wbData,
    output isaPkg::execBundleT   out,
    output logic                 redirect,
    output isaPkg::wordT         redirectPc
);

    isaPkg::wordT srcA;
    isaPkg::wordT srcB;
    isaPkg::wordT opB;
    isaPkg::wordT aluResult;
    logic         zero;
    logic         taken;

    // the producer one slot ahead sits in writeback
    always_comb begin
        srcA = in.rd1Val;
        srcB = in.rd2Val;
        if (wbWrite && wbRd != '0 && wbRd == in.rs1) begin
            srcA = wbData;
        end
        if (wbWrite && wbRd != '0 && wbRd == in.rs2) begin
            srcB = wbData;
        end
    end

    assign opB = in.aluSrc ? in.imm : srcB;

    always_comb begin
        case (in.aluOp)
            isaPkg::aluAdd:   aluResult = srcA + opB;
            isaPkg::aluSub:   aluResult = srcA - opB;
            isaPkg::aluAnd:   aluResult = srcA & opB;
            isaPkg::aluOr:    aluResult = srcA | opB;
            isaPkg::aluXor:   aluResult = srcA ^ opB;
            isaPkg::aluSlt:   aluResult = {31'b0, $signed(srcA) < $signed(opB)};
            isaPkg::aluPassB: aluResult = opB;
            default:          aluResult = '0;
        endcase
    end

    assign zero  = (aluResult == '0);
    assign taken = in.jump || (in.branch && (zero ^ in.branchNe));  // bubbles carry no control

    assign redirect   = taken && !stall;           // frozen pipe cannot redirect
    assign redirectPc = in.pc + in.imm;

    always_comb begin
        out           = '0;
        out.valid     = in.valid;
        out.regWrite  = in.regWrite;
        out.memWrite  = in.memWrite;
        out.rd        = in.rd;
        out.result    = in.resultSrc ? in.pcPlus4 : aluResult;
        out.storeData = srcB;
    end

    always_comb begin
        if (redirect) begin
            assert (in.valid) else $error("executeStage: redirect from a bubble");
        end
    end

endmodule

// File: hw/writebackStage.sv
`timescale 1ns/1ps

module writebackStage (
    input  logic                        clk,
    input  logic                        rstN,
    input  isaPkg::execBundleT          in,
    input  logic                        dAck,
    output logic                        dCyc,
    output logic                        dStb,
    output logic                        dWe,
    output logic [busPkg::adrWidth-1:0] dAdr,
    output logic [busPkg::datWidth-1:0] dDatO,
    output logic [busPkg::selWidth-1:0] dSel,
    output logic                        stall,
    output logic                        wbWrite,
    output isaPkg::regIdxT              wbRd,
    output isaPkg::wordT                wbData
);

    logic storeReq;
    logic storeDone;
    logic busGap;                                  // idle bus cycle after an ack

    assign storeReq  = in.valid && in.memWrite;
    assign dCyc      = storeReq && !busGap;
    assign dStb      = dCyc;
    assign dWe       = dCyc;                       // write-only port
    assign dAdr      = in.result;
    assign dDatO     = in.storeData;
    assign dSel      = '1;                         // word stores only
    assign storeDone = dCyc && dAck;

    // whole pipe waits on the store, released on the ack edge
    assign stall = storeReq && !storeDone;

    assign wbWrite = in.valid && in.regWrite && (!in.memWrite || storeDone);
    assign wbRd    = in.rd;
    assign wbData  = in.result;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busGap <= 1'b0;
        end else begin
            busGap <= storeDone;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        dCyc && !dAck |=> dCyc && $stable(dAdr) && $stable(dDatO))
        else $error("writebackStage: store cycle changed before dAck");

endmodule

// File: hw/coreTop.sv
`timescale 1ns/1ps

module coreTop (
    input  logic                        clk,
    input  logic                        rstN,
    output logic                        iCyc,
    output logic                        iStb,
    output isaPkg::wordT                iAdr,
    input  isaPkg::wordT                iDatI,
    input  logic                        iAck,
    output logic                        dCyc,
    output logic                        dStb,
    output logic                        dWe,
    output logic [busPkg::adrWidth-1:0] dAdr,
    output logic [busPkg::datWidth-1:0] dDatO,
    output logic [busPkg::selWidth-1:0] dSel,
    input  logic                        dAck
);

    logic                 stall;
    logic                 redirect;
    isaPkg::wordT         redirectPc;
    logic                 instrValid;
    isaPkg::wordT         instr;
    isaPkg::wordT         instrPc;
    logic                 wbWrite;
    isaPkg::regIdxT       wbRd;
    isaPkg::wordT         wbData;
    isaPkg::decodeBundleT decBundle;
    isaPkg::decodeBundleT exeBundle;
    isaPkg::execBundleT   exeOut;
    isaPkg::execBundleT   wbBundle;

    fetchStage fetch0 (
        .clk, .rstN, .stall, .redirect, .redirectPc,
        .iDatI, .iAck, .iCyc, .iStb, .iAdr,
        .instrValid, .instr, .instrPc
    );

    decodeStage decode0 (
        .clk, .rstN, .instrValid, .instr, .instrPc,
        .wbWrite, .wbRd, .wbData,
        .bundle (decBundle)
    );

    //////////////////////////////////////////////////////////////////////
    // stage registers, only decode-to-execute is ever flushed
    //////////////////////////////////////////////////////////////////////
    stageReg #(.payloadT(isaPkg::decodeBundleT)) decToExe (
        .clk, .rstN, .stall, .flush (redirect), .d (decBundle), .q (exeBundle)
    );

    executeStage execute0 (
        .stall, .in (exeBundle), .wbWrite, .wbRd, .wbData,
        .out (exeOut), .redirect, .redirectPc
    );

    stageReg #(.payloadT(isaPkg::execBundleT)) exeToWb (
        .clk, .rstN, .stall, .flush (1'b0), .d (exeOut), .q (wbBundle)
    );

    writebackStage writeback0 (
        .clk, .rstN, .in (wbBundle), .dAck,
        .dCyc, .dStb, .dWe, .dAdr, .dDatO, .dSel,
        .stall, .wbWrite, .wbRd, .wbData
    );

endmodule

// File: dv/coreTb.sv
`timescale 1ns/1ps

module coreTb;

    localparam int timeoutCycles = 2000;
    localparam int quietCycles   = 60;             // window to catch extra stores

    logic                        clk;
    logic                        rstN;
    logic                        iCyc;
    logic                        iStb;
    isaPkg::wordT                iAdr;
    isaPkg::wordT                iDatI;
    logic                        iAck;
    logic                        dCyc;
    logic                        dStb;
    logic                        dWe;
    logic [busPkg::adrWidth-1:0] dAdr;
    logic [busPkg::datWidth-1:0] dDatO;
    logic [busPkg::selWidth-1:0] dSel;
    logic                        dAck;

    isaPkg::wordT imem [64];
    isaPkg::wordT prog [$];
    isaPkg::wordT expAdr [$];
    isaPkg::wordT expDat [$];
    isaPkg::wordT stAdr [$];
    isaPkg::wordT stDat [$];
    int           iDelay;
    logic         iPending;
    int           dDelay;
    logic         dPending;
    int           dAckMax;
    int           seedVal;

    coreTop dut0 (
        .clk, .rstN, .iCyc, .iStb, .iAdr, .iDatI, .iAck,
        .dCyc, .dStb, .dWe, .dAdr, .dDatO, .dSel, .dAck
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic checkWord(input string name, input isaPkg::wordT got,
                             input isaPkg::wordT exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic checkAdr(input string name, input isaPkg::wordT got,
                            input isaPkg::wordT exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "address mismatch");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus slave models
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!rstN || iAck) begin
            iAck     = 1'b0;                       // one-cycle ack
            iPending = 1'b0;
        end else if (iCyc) begin
            checkWord("iStb", {31'b0, iStb}, 32'h1);
            if (!iPending) begin
                iPending = 1'b1;
                iDelay   = $urandom_range(3, 0);
            end
            if (iDelay == 0) begin
                iAck  = 1'b1;
                iDatI = imem[iAdr[7:2]];
            end else begin
                iDelay--;
            end
        end else begin
            checkWord("iStb", {31'b0, iStb}, 32'h0);
        end
    end

    always @(negedge clk) begin
        if (!rstN || dAck) begin
            dAck     = 1'b0;
            dPending = 1'b0;
        end else if (dCyc) begin
            checkWord("dStb", {31'b0, dStb}, 32'h1);
            if (!dPending) begin
                dPending = 1'b1;
                dDelay   = $urandom_range(dAckMax, 0);
            end
            if (dDelay == 0) begin
                checkWord("dSel", {28'b0, dSel}, 32'hf);
                checkWord("dWe", {31'b0, dWe}, 32'h1);
                dAck = 1'b1;
                stAdr.push_back(dAdr);             // log at retirement
                stDat.push_back(dDatO);
            end else begin
                dDelay--;
            end
        end else begin
            checkWord("dStb", {31'b0, dStb}, 32'h0);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // instruction encoders
    //////////////////////////////////////////////////////////////////////
    function automatic isaPkg::wordT encR(input logic [6:0] f7, input isaPkg::regIdxT rs2,
            input isaPkg::regIdxT rs1, input logic [2:0] f3, input isaPkg::regIdxT rd);
        return {f7, rs2, rs1, f3, rd, isaPkg::opReg};
    endfunction

    function automatic isaPkg::wordT encI(input logic [11:0] imm, input isaPkg::regIdxT rs1,
            input logic [2:0] f3, input isaPkg::regIdxT rd);
        return {imm, rs1, f3, rd, isaPkg::opImm};
    endfunction

    function automatic isaPkg::wordT encLui(input logic [19:0] imm, input isaPkg::regIdxT rd);
        return {imm, rd, isaPkg::opLui};
    endfunction

    function automatic isaPkg::wordT encS(input logic [11:0] imm, input isaPkg::regIdxT rs2,
            input isaPkg::regIdxT rs1);
        return {imm[11:5], rs2, rs1, isaPkg::f3Sw, imm[4:0], isaPkg::opStore};
    endfunction

    function automatic isaPkg::wordT encB(input logic [12:0] imm, input isaPkg::regIdxT rs2,
            input isaPkg::regIdxT rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isaPkg::opBranch};
    endfunction

    function automatic isaPkg::wordT encJal(input logic [20:0] imm, input isaPkg::regIdxT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isaPkg::opJal};
    endfunction

    function automatic isaPkg::wordT signExt12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // program and run helpers
    //////////////////////////////////////////////////////////////////////
    task automatic clearProgram();
        prog.delete();
        expAdr.delete();
        expDat.delete();
    endtask

    // store rs to a fixed address off x0 and expect val there
    task automatic pushStore(input isaPkg::regIdxT rs, input isaPkg::wordT adr,
                             input isaPkg::wordT val);
        prog.push_back(encS(adr[11:0], rs, 5'd0));
        expAdr.push_back(adr);
        expDat.push_back(val);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 64; i++) begin
            if (i < prog.size()) begin
                imem[i] = prog[i];
            end else begin
                imem[i] = {i[24:0], 7'h7f};        // unknown opcode, never reached
            end
        end
    endtask

    task automatic resetCore(input int maxAck);
        @(negedge clk);
        rstN    = 1'b0;
        dAckMax = maxAck;
        stAdr.delete();
        stDat.delete();
        loadProgram();
        repeat (2) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic waitStores(input int count);
        int cycles;
        cycles = 0;
        while (stAdr.size() < count) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeoutCycles) begin
                $display("Simulation FAILED");
                $fatal(1, "timed out waiting for %0d stores, saw %0d", count, stAdr.size());
            end
        end
        repeat (quietCycles) @(negedge clk);
        if (stAdr.size() != count) begin
            $display("Simulation FAILED");
            $fatal(1, "expected %0d stores but the core made %0d", count, stAdr.size());
        end
    endtask

    task automatic runProgram(input int maxAck);
        prog.push_back(encJal(21'd0, 5'd0));       // self-loop ends the program
        resetCore(maxAck);
        waitStores(expAdr.size());
        for (int i = 0; i < expAdr.size(); i++) begin
            checkAdr("dAdr", stAdr[i], expAdr[i]);
            checkWord("dDatO", stDat[i], expDat[i]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic testResetState();
        int cycles;
        clearProgram();
        prog.push_back(encJal(21'd0, 5'd0));
        resetCore(3);
        cycles = 0;
        checkWord("iCyc", {31'b0, iCyc}, 32'h0);
        checkWord("dCyc", {31'b0, dCyc}, 32'h0);
        while (!iCyc) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeoutCycles) begin
                $display("Simulation FAILED");
                $fatal(1, "first instruction fetch never started");
            end
        end
        checkAdr("iAdr", iAdr, busPkg::resetPc);
        checkWord("dCyc", {31'b0, dCyc}, 32'h0);
    endtask

    task automatic testAluOps(input int maxAck);
        isaPkg::wordT a;
        isaPkg::wordT b;
        isaPkg::wordT u;
        a = 32'h123;
        b = signExt12(12'hffb);
        u = {20'habcde, 12'h0};
        clearProgram();
        prog.push_back(encI(12'h123, 5'd0, isaPkg::f3AddSub, 5'd1));
        prog.push_back(encI(12'hffb, 5'd0, isaPkg::f3AddSub, 5'd2));
        prog.push_back(encLui(20'habcde, 5'd3));
        prog.push_back(encR(isaPkg::f7Base, 5'd2, 5'd1, isaPkg::f3AddSub, 5'd4));
        pushStore(5'd4, 32'h100, a + b);
        prog.push_back(encR(isaPkg::f7Sub, 5'd2, 5'd1, isaPkg::f3AddSub, 5'd5));
        pushStore(5'd5, 32'h104, a - b);
        prog.push_back(encR(isaPkg::f7Base, 5'd2, 5'd1, isaPkg::f3And, 5'd6));
        pushStore(5'd6, 32'h108, a & b);
        prog.push_back(encR(isaPkg::f7Base, 5'd2, 5'd1, isaPkg::f3Or, 5'd7));
        pushStore(5'd7, 32'h10c, a | b);
        prog.push_back(encR(isaPkg::f7Base, 5'd2, 5'd1, isaPkg::f3Xor, 5'd8));
        pushStore(5'd8, 32'h110, a ^ b);
        prog.push_back(encR(isaPkg::f7Base, 5'd1, 5'd2, isaPkg::f3Slt, 5'd9));
        pushStore(5'd9, 32'h114, {31'b0, $signed(b) < $signed(a)});
        prog.push_back(encR(isaPkg::f7Base, 5'd2, 5'd1, isaPkg::f3Slt, 5'd10));
        pushStore(5'd10, 32'h118, {31'b0, $signed(a) < $signed(b)});
        prog.push_back(encI(12'h0f0, 5'd1, isaPkg::f3And, 5'd11));
        pushStore(5'd11, 32'h11c, a & signExt12(12'h0f0));
        prog.push_back(encI(12'h100, 5'd2, isaPkg::f3Or, 5'd12));
        pushStore(5'd12, 32'h120, b | signExt12(12'h100));
        prog.push_back(encI(12'hfff, 5'd1, isaPkg::f3Xor, 5'd13));
        pushStore(5'd13, 32'h124, a ^ signExt12(12'hfff));
        pushStore(5'd3, 32'h128, u);
        prog.push_back(encI(12'h7ff, 5'd3, isaPkg::f3AddSub, 5'd14));
        pushStore(5'd14, 32'h12c, u + signExt12(12'h7ff));
        runProgram(maxAck);
    endtask

    // padded runs put independent instructions between producer and consumer
    task automatic testForwarding(input bit padded);
        isaPkg::wordT v1;
        isaPkg::wordT v2;
        isaPkg::wordT v3;
        isaPkg::wordT v4;
        v1 = 32'd7 + 32'd3;
        v2 = v1 + v1;
        v3 = v2 - v1;
        v4 = v3 ^ v2;
        clearProgram();
        prog.push_back(encI(12'd7, 5'd0, isaPkg::f3AddSub, 5'd1));
        for (int k = 0; k < 5; k++) begin
            if (padded) begin
                prog.push_back(encI(12'd1, 5'd0, isaPkg::f3AddSub, 5'd20));
                prog.push_back(encI(12'd2, 5'd0, isaPkg::f3AddSub, 5'd21));
            end
            case (k)
                0: prog.push_back(encI(12'd3, 5'd1, isaPkg::f3AddSub, 5'd1));
                1: prog.push_back(encR(isaPkg::f7Base, 5'd1, 5'd1, isaPkg::f3AddSub, 5'd2));
                2: prog.push_back(encR(isaPkg::f7Sub, 5'd1, 5'd2, isaPkg::f3AddSub, 5'd3));
                3: prog.push_back(encR(isaPkg::f7Base, 5'd2, 5'd3, isaPkg::f3Xor, 5'd4));
                default: prog.push_back(encR(isaPkg::f7Base, 5'd4, 5'd3, isaPkg::f3Slt, 5'd5));
            endcase
        end
        pushStore(5'd5, 32'h400, {31'b0, $signed(v3) < $signed(v4)});
        pushStore(5'd4, 32'h404, v4);
        pushStore(5'd2, 32'h408, v2);
        runProgram(3);
    endtask

    task automatic testBranches();
        clearProgram();
        prog.push_back(encI(12'd5, 5'd0, isaPkg::f3AddSub, 5'd1));
        prog.push_back(encI(12'd5, 5'd0, isaPkg::f3AddSub, 5'd2));
        prog.push_back(encI(12'd9, 5'd0, isaPkg::f3AddSub, 5'd3));
        prog.push_back(encB(13'd12, 5'd2, 5'd1, isaPkg::f3Beq));    // taken
        prog.push_back(encS(12'h200, 5'd1, 5'd0));
        prog.push_back(encS(12'h204, 5'd1, 5'd0));
        pushStore(5'd3, 32'h208, 32'd9);
        prog.push_back(encB(13'd12, 5'd3, 5'd1, isaPkg::f3Bne));    // taken
        prog.push_back(encS(12'h20c, 5'd1, 5'd0));
        prog.push_back(encS(12'h210, 5'd1, 5'd0));
        pushStore(5'd2, 32'h214, 32'd5);
        prog.push_back(encB(13'd12, 5'd3, 5'd1, isaPkg::f3Beq));    // not taken
        pushStore(5'd3, 32'h218, 32'd9);
        pushStore(5'd1, 32'h21c, 32'd5);
        pushStore(5'd2, 32'h220, 32'd5);
        prog.push_back(encB(13'd12, 5'd2, 5'd1, isaPkg::f3Bne));    // not taken
        pushStore(5'd1, 32'h224, 32'd5);
        pushStore(5'd3, 32'h228, 32'd9);
        runProgram(3);
    endtask

    task automatic testJal();
        isaPkg::wordT jalPc;
        clearProgram();
        prog.push_back(encI(12'd42, 5'd0, isaPkg::f3AddSub, 5'd1));
        jalPc = 32'(prog.size()) * 32'd4;
        prog.push_back(encJal(21'd12, 5'd5));
        prog.push_back(encS(12'h300, 5'd1, 5'd0));
        prog.push_back(encS(12'h304, 5'd1, 5'd0));
        pushStore(5'd5, 32'h308, jalPc + 32'd4);
        pushStore(5'd1, 32'h30c, 32'd42);
        runProgram(3);
    endtask

    // same program and log as the ALU test, with long stalls on every store
    task automatic testBackPressure();
        testAluOps(8);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        rstN     = 1'b0;
        iAck     = 1'b0;
        iDatI    = '0;
        dAck     = 1'b0;
        iDelay   = 0;
        iPending = 1'b0;
        dDelay   = 0;
        dPending = 1'b0;
        dAckMax  = 3;
        seedVal  = $urandom(32'h29a);
        testResetState();
        testAluOps(3);
        testForwarding(1'b0);
        testForwarding(1'b1);
        testBranches();
        testJal();
        testBackPressure();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: all.f
hw/isaPkg.sv
hw/busPkg.sv
hw/stageReg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/writebackStage.sv
hw/coreTop.sv
dv/coreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator.
# The exit status is nonzero when the build fails or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f \
    --top-module coreTb \
    --Mdir obj_dir \
    -o coreSim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/coreSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
